//--- Bender.yml
package:
  name: intc_subsys

sources:
  - include_dirs:
      - .
    files:
      - intc_pkg.sv
      - ext_irq_sync.sv
      - int_ctrl.sv
      - irq_timer.sv
      - wb_slave_mux.sv
      - intc_subsys_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_intc_subsys.sv

//--- ext_irq_sync.sv
// external interrupt line synchronizer with rising edge detect
`timescale 1ns/100ps
`include "intc_defines.svh"

module ext_irq_sync (
    input  logic                     clk,
    input  logic                     reset,
    input  logic [`INTC_EXT_NUM-1:0] line_i,   // asynchronous levels
    output logic [`INTC_EXT_NUM-1:0] irq_o     // one pulse per rising edge
);

    logic [`INTC_EXT_NUM-1:0] sync1_q;   // may go metastable
    logic [`INTC_EXT_NUM-1:0] sync2_q;   // settled level
    logic [`INTC_EXT_NUM-1:0] prev_q;    // level one cycle back

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            sync1_q <= '0;
            sync2_q <= '0;
            prev_q  <= '0;
        end else begin
            sync1_q <= line_i;
            sync2_q <= sync1_q;
            prev_q  <= sync2_q;
        end
    end

    // high only in the first cycle a line reads high, held lines stay quiet
    assign irq_o = sync2_q & ~prev_q;

endmodule

//--- int_ctrl.sv
// interrupt controller that masks and latches source pulses and drives one core interrupt pin
`timescale 1ns/100ps
`include "intc_defines.svh"

module int_ctrl
    import intc_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  wb_req_t  req_i,   // stb already gated by the mux
    output wb_rsp_t  rsp_o,
    input  irq_vec_t irq_i,   // one-cycle source pulses
    output logic     int_o    // level to the core
);

    logic [`INTC_REG_AW-1:0] reg_addr;
    irq_vec_t                wr_bits;     // write data cut to source count
    logic [1:0]              mer, mer_next;
    irq_vec_t                ier, ier_next;
    irq_vec_t                iar, iar_next;
    irq_vec_t                ipr, ipr_next;
    irq_vec_t                rd_q, rd_next;  // last read value
    logic                    ack_q;

    assign reg_addr = req_i.addr[`INTC_REG_AW-1:0];
    assign wr_bits  = req_i.dat[`INTC_INT_NUM-1:0];

    always_comb begin
        mer_next = mer;
        ier_next = ier;
        iar_next = iar & ~irq_i;         // new pulse re-arms the source
        ipr_next = (ipr | irq_i) & ier;  // only enabled sources pend
        rd_next  = rd_q;
        if (req_i.stb) begin
            if (req_i.we) begin
                case (reg_addr)
                    `INTC_MER_ADDR: mer_next = req_i.dat[1:0];
                    `INTC_IER_ADDR: ier_next = wr_bits;
                    `INTC_IAR_ADDR: begin
                        // a written 1 sets iar and drops the pending bit
                        iar_next = iar_next | wr_bits;
                        ipr_next = ipr_next & ~wr_bits;
                    end
                    default: ;  // ipr and unused offsets ignore writes
                endcase
            end else begin
                case (reg_addr)
                    `INTC_MER_ADDR: rd_next = {{(`INTC_INT_NUM-2){1'b0}}, mer};
                    `INTC_IER_ADDR: rd_next = ier;
                    `INTC_IAR_ADDR: rd_next = iar;
                    `INTC_IPR_ADDR: rd_next = ipr;
                    default:        rd_next = rd_q;  // keep old value
                endcase
            end
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            mer   <= '0;
            ier   <= '0;
            iar   <= '0;
            ipr   <= '0;
            rd_q  <= '0;
            ack_q <= 1'b0;
        end else begin
            mer   <= mer_next;
            ier   <= ier_next;
            iar   <= iar_next;
            ipr   <= ipr_next;
            rd_q  <= rd_next;
            ack_q <= req_i.stb && !ack_q;  // one-shot ack
        end
    end

    // core sees an interrupt only with both master enable bits set
    assign int_o = (mer == 2'b11) && ((ier & ipr) != '0);

    assign rsp_o = '{
        dat: {{(`INTC_DW-`INTC_INT_NUM){1'b0}}, rd_q},
        ack: ack_q,
        err: 1'b0,
        rty: 1'b0
    };

endmodule

//--- intc_defines.svh
// interrupt subsystem widths, slave select codes and register offsets
`ifndef INTC_DEFINES_SVH
`define INTC_DEFINES_SVH

`define INTC_DW       32     // bus data width
`define INTC_SELW     4      // byte select width, carried only
`define INTC_REG_AW   3      // register address bits inside one slave
`define INTC_AW       5      // full bus address, top bits pick the slave
`define INTC_INT_NUM  4      // interrupt sources into the controller
`define INTC_EXT_NUM  3      // external lines, sources 1 to 3

// slave select codes on addr[4:3]
`define INTC_SEL_INTC 2'd0
`define INTC_SEL_TMR  2'd1

// controller registers
`define INTC_MER_ADDR 3'd0   // master enable, 2 bits
`define INTC_IER_ADDR 3'd1   // per source enable
`define INTC_IAR_ADDR 3'd2   // acknowledge, write 1 to ack
`define INTC_IPR_ADDR 3'd3   // pending

// timer registers
`define INTC_TMR_CTRL_ADDR  3'd0  // bit 0 runs the counter
`define INTC_TMR_LOAD_ADDR  3'd1  // wrap compare value
`define INTC_TMR_COUNT_ADDR 3'd2  // current count, read only

`endif

//--- intc_pkg.sv
// shared bus request/response structs and interrupt vector type
`include "intc_defines.svh"

package intc_pkg;

    // request from the master, held until ack
    typedef struct packed {
        logic [`INTC_DW-1:0]   dat;   // write data
        logic [`INTC_SELW-1:0] sel;   // byte selects, not decoded
        logic [`INTC_AW-1:0]   addr;  // slave select + register offset
        logic                  stb;   // access request
        logic                  we;    // 1 = write
    } wb_req_t;

    // slave response
    typedef struct packed {
        logic [`INTC_DW-1:0] dat;     // read data, valid with ack
        logic                ack;     // one-shot, cycle after stb
        logic                err;     // unused, always low
        logic                rty;     // unused, always low
    } wb_rsp_t;

    // one bit per interrupt source, bit 0 is the timer
    typedef logic [`INTC_INT_NUM-1:0] irq_vec_t;

endpackage

//--- intc_subsys_top.sv
// interrupt subsystem top: bus decoder, controller, timer and external line sync
`timescale 1ns/100ps
`include "intc_defines.svh"

module intc_subsys_top
    import intc_pkg::*;
(
    input  logic                     clk,
    input  logic                     reset,
    input  wb_req_t                  req_i,      // from the core
    output wb_rsp_t                  rsp_o,
    input  logic [`INTC_EXT_NUM-1:0] ext_irq_i,  // asynchronous lines
    output logic                     int_o       // to the core interrupt pin
);

    wb_req_t                  intc_req, tmr_req;
    wb_rsp_t                  intc_rsp, tmr_rsp;
    logic                     tmr_irq;
    logic [`INTC_EXT_NUM-1:0] ext_irq;
    irq_vec_t                 irq_vec;

    // timer is source 0, external lines above it
    assign irq_vec = {ext_irq, tmr_irq};

    wb_slave_mux mux_i (
        .req_i      (req_i),
        .intc_req_o (intc_req),
        .tmr_req_o  (tmr_req),
        .intc_rsp_i (intc_rsp),
        .tmr_rsp_i  (tmr_rsp),
        .rsp_o      (rsp_o)
    );

    int_ctrl intc_i (
        .clk   (clk),
        .reset (reset),
        .req_i (intc_req),
        .rsp_o (intc_rsp),
        .irq_i (irq_vec),
        .int_o (int_o)
    );

    irq_timer tmr_i (
        .clk   (clk),
        .reset (reset),
        .req_i (tmr_req),
        .rsp_o (tmr_rsp),
        .irq_o (tmr_irq)
    );

    ext_irq_sync sync_i (
        .clk    (clk),
        .reset  (reset),
        .line_i (ext_irq_i),
        .irq_o  (ext_irq)
    );

endmodule

//--- intc_tests.txt
# each line holds opcode, test name, address, value and expected value, numbers in hex
# W write  R read and compare  E set ext lines to value  C idle value cycles  I check int_o
R rst_mer     00 0        0
R rst_ier     01 0        0
R rst_iar     02 0        0
R rst_ipr     03 0        0
R rst_count   0a 0        0
I rst_int     00 0        0
W ier_all     01 ffffffff 0
R ier_trunc   01 0        f
W mer_wr      00 fffffffe 0
R mer_trunc   00 0        2
# master enable gating on line 1
W ier_src1    01 2        0
E line1_rise  00 1        0
C line1_sync  00 4        0
R ipr_src1    03 0        2
I int_mer_off 00 0        0
W mer_on      00 3        0
I int_mer_on  00 0        1
# acknowledge and re-arm
W iar_ack1    02 2        0
R ipr_acked   03 0        0
I int_acked   00 0        0
R iar_set     02 0        2
E line1_fall  00 0        0
C line1_low   00 4        0
E line1_rise2 00 1        0
C line1_sync2 00 4        0
R iar_rearm   02 0        0
R ipr_again   03 0        2
I int_again   00 0        1
W iar_ack2    02 2        0
# masking, line 2 with its enable clear
E line2_rise  00 3        0
C line2_sync  00 4        0
R ipr_masked  03 0        0
I int_masked  00 0        0
# edge only, line 3 held high
W ier_src3    01 8        0
E line3_rise  00 7        0
C line3_sync  00 4        0
R ipr_src3    03 0        8
W iar_ack3    02 8        0
C line3_held  00 28       0
R ipr_held    03 0        0
E line3_fall  00 3        0
C line3_low   00 4        0
E line3_rise2 00 7        0
C line3_sync2 00 4        0
R ipr_src3b   03 0        8
# timer, reload 20 then 30 idle cycles
W ier_tmr     01 1        0
W tmr_load    09 14       0
W tmr_run     08 1        0
C tmr_wait    00 1e       0
I int_tmr     00 0        1
R tmr_count   0a 0        a
R ipr_tmr     03 0        1
W tmr_stop    08 0        0
W iar_tmr     02 1        0
I int_tmr_clr 00 0        0

//--- irq_timer.sv
// interval timer slave: counts to a reload value, wraps and pulses an interrupt
`timescale 1ns/100ps
`include "intc_defines.svh"

module irq_timer
    import intc_pkg::*;
(
    input  logic    clk,
    input  logic    reset,
    input  wb_req_t req_i,
    output wb_rsp_t rsp_o,
    output logic    irq_o     // one cycle per wrap
);

    logic [`INTC_REG_AW-1:0] reg_addr;
    logic                    wr_en;
    logic                    run_q;          // CTRL bit 0
    logic [`INTC_DW-1:0]     load_q;
    logic [`INTC_DW-1:0]     count_q;
    logic [`INTC_DW-1:0]     rd_q;
    logic                    ack_q;
    logic                    wrap;

    assign reg_addr = req_i.addr[`INTC_REG_AW-1:0];
    assign wr_en    = req_i.stb && req_i.we;
    assign wrap     = run_q && (count_q == load_q);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            run_q   <= 1'b0;
            load_q  <= '0;
            count_q <= '0;
            rd_q    <= '0;
            ack_q   <= 1'b0;
            irq_o   <= 1'b0;
        end else begin
            ack_q <= req_i.stb && !ack_q;
            irq_o <= wrap;
            // count, a control or load write restarts from zero
            if (wr_en && (reg_addr == `INTC_TMR_CTRL_ADDR ||
                          reg_addr == `INTC_TMR_LOAD_ADDR)) begin
                count_q <= '0;
            end else if (wrap) begin
                count_q <= '0;
            end else if (run_q) begin
                count_q <= count_q + 1'b1;
            end
            if (wr_en && reg_addr == `INTC_TMR_CTRL_ADDR) begin
                run_q <= req_i.dat[0];
            end
            if (wr_en && reg_addr == `INTC_TMR_LOAD_ADDR) begin
                load_q <= req_i.dat;
            end
            if (req_i.stb && !req_i.we) begin
                case (reg_addr)
                    `INTC_TMR_CTRL_ADDR:  rd_q <= {{(`INTC_DW-1){1'b0}}, run_q};
                    `INTC_TMR_LOAD_ADDR:  rd_q <= load_q;
                    `INTC_TMR_COUNT_ADDR: rd_q <= count_q;
                    default:              rd_q <= rd_q;
                endcase
            end
        end
    end

    assign rsp_o = '{dat: rd_q, ack: ack_q, err: 1'b0, rty: 1'b0};

endmodule

//--- tb.f
+incdir+.
intc_pkg.sv
ext_irq_sync.sv
int_ctrl.sv
irq_timer.sv
wb_slave_mux.sv
intc_subsys_top.sv
tb_intc_subsys.sv

//--- tb_intc_subsys.sv
// testbench for the interrupt subsystem that plays the core and runs the steps in intc_tests.txt
`timescale 1ns/100ps
`include "intc_defines.svh"

module tb_intc_subsys
    import intc_pkg::*;
();

    localparam int CLK_HALF = 5;          // 10 ns period

    logic                     clk;
    logic                     reset;
    wb_req_t                  req;
    wb_rsp_t                  rsp;
    logic [`INTC_EXT_NUM-1:0] ext_lines;  // external interrupt lines
    logic                     int_line;   // core interrupt pin

    // one entry per test step
    string               op_q[$];
    string               name_q[$];
    logic [`INTC_AW-1:0] addr_q[$];
    logic [`INTC_DW-1:0] val_q[$];
    logic [`INTC_DW-1:0] exp_q[$];
    logic                loaded;          // watchdog starts once steps are known

    intc_subsys_top dut_i (
        .clk       (clk),
        .reset     (reset),
        .req_i     (req),
        .rsp_o     (rsp),
        .ext_irq_i (ext_lines),
        .int_o     (int_line)
    );

    always #CLK_HALF clk = ~clk;

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Simulation FAILED");
        $fatal(1, "run stopped at first error");
    endtask

    // read data of one bus response
    task automatic check_rsp(input string name, input logic [`INTC_DW-1:0] exp_dat,
                             input wb_rsp_t act);
        if (act.dat !== exp_dat) begin
            fail_run($sformatf("[FAIL] %s: expected 0x%h, actual 0x%h", name, exp_dat, act.dat));
        end
    endtask

    // level of the core interrupt pin
    task automatic check_irq(input string name, input logic exp_int, input logic act_int);
        if (act_int !== exp_int) begin
            fail_run($sformatf("[FAIL] %s: expected %b, actual %b", name, exp_int, act_int));
        end
    endtask

    task automatic idle(input int cycles);
        repeat (cycles) begin
            @(posedge clk);
            #1;
        end
    endtask

    // one access with ack expected exactly one cycle after stb
    task automatic bus_access(input string name, input logic we,
                              input logic [`INTC_AW-1:0] addr,
                              input logic [`INTC_DW-1:0] wdat, output wb_rsp_t got);
        if (rsp.ack !== 1'b0) begin
            fail_run($sformatf("%s: ack was already high before stb rose", name));
        end
        req.dat  = wdat;
        req.sel  = '1;            // carried but not decoded
        req.addr = addr;
        req.we   = we;
        req.stb  = 1'b1;
        idle(1);
        got = rsp;
        if (got.ack !== 1'b1) begin
            fail_run($sformatf("%s: no ack one cycle after stb at address 0x%h", name, addr));
        end
        if (got.err !== 1'b0 || got.rty !== 1'b0) begin
            fail_run($sformatf("%s: error or retry raised at address 0x%h", name, addr));
        end
        req.stb = 1'b0;
        req.we  = 1'b0;
        idle(1);                  // stb low for a cycle
    endtask

    task automatic load_tests();
        int                  fd;
        int                  n;
        string               line;
        string               op;
        string               name;
        logic [`INTC_AW-1:0] addr;
        logic [`INTC_DW-1:0] val;
        logic [`INTC_DW-1:0] exp_v;
        fd = $fopen("intc_tests.txt", "r");
        if (fd == 0) begin
            fail_run("could not open the test file intc_tests.txt");
        end
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (n > 0 && line.getc(0) != "#") begin   // skip comment lines
                n = $sscanf(line, "%s %s %h %h %h", op, name, addr, val, exp_v);
                if (n == 5) begin
                    op_q.push_back(op);
                    name_q.push_back(name);
                    addr_q.push_back(addr);
                    val_q.push_back(val);
                    exp_q.push_back(exp_v);
                end else if (n > 0) begin
                    fail_run($sformatf("test file line could not be parsed: %s", line));
                end
            end
        end
        $fclose(fd);
    endtask

    task automatic run_step(input int i);
        wb_rsp_t got;
        case (op_q[i])
            "W": bus_access(name_q[i], 1'b1, addr_q[i], val_q[i], got);
            "R": begin
                bus_access(name_q[i], 1'b0, addr_q[i], '0, got);
                check_rsp(name_q[i], exp_q[i], got);
            end
            "E": begin
                ext_lines = val_q[i][`INTC_EXT_NUM-1:0];
                idle(1);
            end
            "C": idle(val_q[i]);
            "I": check_irq(name_q[i], exp_q[i][0], int_line);
            default: fail_run($sformatf("unknown opcode %s in step %s", op_q[i], name_q[i]));
        endcase
    endtask

    // watchdog scaled by the number of steps
    initial begin
        longint limit_ns;
        wait (loaded === 1'b1);
        limit_ns = (longint'(op_q.size()) * 40 + 2000) * 10;
        #(limit_ns);
        fail_run("watchdog expired before all test steps finished");
    end

    initial begin
        clk       = 1'b0;
        reset     = 1'b1;
        req       = '0;
        ext_lines = '0;
        loaded    = 1'b0;
        load_tests();
        loaded = 1'b1;
        repeat (4) @(posedge clk);   // reset held 4 cycles
        #1;
        reset = 1'b0;
        idle(1);
        for (int i = 0; i < op_q.size(); i++) begin
            run_step(i);
        end
        if (op_q.size() > 0) begin
            $display("Simulation PASSED");
            $finish;
        end else begin
            fail_run("the test file held no steps to run");
        end
    end

endmodule

//--- wb_slave_mux.sv
// bus decoder: steers one request to the controller or timer, returns its response
`timescale 1ns/100ps
`include "intc_defines.svh"

module wb_slave_mux
    import intc_pkg::*;
(
    input  wb_req_t req_i,
    output wb_req_t intc_req_o,
    output wb_req_t tmr_req_o,
    input  wb_rsp_t intc_rsp_i,
    input  wb_rsp_t tmr_rsp_i,
    output wb_rsp_t rsp_o
);

    logic [`INTC_AW-`INTC_REG_AW-1:0] slv_sel;  // addr[4:3]

    assign slv_sel = req_i.addr[`INTC_AW-1:`INTC_REG_AW];

    always_comb begin
        // full request to both, slaves decode the low bits
        intc_req_o     = req_i;
        tmr_req_o      = req_i;
        intc_req_o.stb = req_i.stb && (slv_sel == `INTC_SEL_INTC);
        tmr_req_o.stb  = req_i.stb && (slv_sel == `INTC_SEL_TMR);
    end

    always_comb begin
        case (slv_sel)
            `INTC_SEL_INTC: rsp_o = intc_rsp_i;
            `INTC_SEL_TMR:  rsp_o = tmr_rsp_i;
            default:        rsp_o = '0;   // no slave, no ack
        endcase
    end

endmodule
